// File: hw/ucode_pkg.sv
package ucode_pkg;

   localparam int IADDR_W = 32;

   typedef logic [2:0] prog_sel_t;

   // One row of the micro-program table
   typedef struct packed {
      logic [2:0] size;
      logic       set_d;
      logic       clear_d;
      logic [2:0] op0;
      logic [2:0] op1;
      logic [2:0] op0_reg;
      logic [2:0] op1_reg;
      logic [3:0] alu_op;
      logic [2:0] flag_0;
      logic [2:0] flag_1;
      logic [1:0] stack_op;
      logic       last;
   } ucode_word_t;

   typedef struct packed {
      logic [IADDR_W-1:0] pc;
      prog_sel_t          prog;
      logic [7:0]         modrm;
      logic [7:0]         sib;
      logic [47:0]        imm;
      logic [31:0]        disp;
      logic [2:0]         seg_override;
      logic               seg_override_valid;
      ucode_word_t        base;
   } dec_instr_t;

   // Instruction operands merged with one table row
   typedef struct packed {
      logic [IADDR_W-1:0] pc;
      logic [7:0]         modrm;
      logic [7:0]         sib;
      logic [47:0]        imm;
      logic [31:0]        disp;
      logic [2:0]         seg_override;
      logic               seg_override_valid;
      ucode_word_t        word;
      logic [4:0]         micro_idx;
   } uop_t;

   // Operand kinds
   localparam logic [2:0] K_NO = 3'd0;
   localparam logic [2:0] K_RG = 3'd1;
   localparam logic [2:0] K_MM = 3'd2;
   localparam logic [2:0] K_IM = 3'd3;
   localparam logic [2:0] K_TM = 3'd4;

   // GPR numbers, x86 order
   localparam logic [2:0] R_AX = 3'd0;
   localparam logic [2:0] R_CX = 3'd1;
   localparam logic [2:0] R_SP = 3'd4;
   localparam logic [2:0] R_BP = 3'd5;
   localparam logic [2:0] R_SI = 3'd6;
   localparam logic [2:0] R_DI = 3'd7;

   localparam logic [3:0] A_PS = 4'd0;
   localparam logic [3:0] A_AD = 4'd1;
   localparam logic [3:0] A_SB = 4'd2;
   localparam logic [3:0] A_AN = 4'd3;

   // Flag update groups
   localparam logic [2:0] F_NO = 3'd0;
   localparam logic [2:0] F_AR = 3'd1;
   localparam logic [2:0] F_ZF = 3'd2;
   localparam logic [2:0] F_CF = 3'd3;

   localparam logic [1:0] S_NO = 2'd0;
   localparam logic [1:0] S_PU = 2'd1;
   localparam logic [1:0] S_PO = 2'd2;

   // size, set_d, clear_d, op0, op1, op0_reg, op1_reg, alu, flag_0, flag_1, stack, last
   localparam ucode_word_t UCODE_ROM [32] = '{
      '{3'd4, 1'b0, 1'b0, K_TM, K_MM, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_TM, K_RG, R_AX, R_CX, A_AD, F_AR, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_MM, K_TM, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_NO, K_NO, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b1},
      // Indirect call through memory
      '{3'd4, 1'b0, 1'b0, K_TM, K_MM, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_SP, R_AX, A_SB, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_MM, K_RG, R_SP, R_BP, A_PS, F_NO, F_NO, S_PU, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_RG, R_BP, R_SP, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_SP, R_AX, A_SB, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_NO, K_TM, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b1},
      // String compare step
      '{3'd1, 1'b0, 1'b1, K_NO, K_NO, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd1, 1'b0, 1'b0, K_TM, K_MM, R_AX, R_SI, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd1, 1'b0, 1'b0, K_TM, K_MM, R_AX, R_DI, A_SB, F_AR, F_ZF, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_SI, R_AX, A_AD, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_DI, R_AX, A_AD, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_CX, R_AX, A_SB, F_ZF, F_NO, S_NO, 1'b0},
      '{3'd1, 1'b1, 1'b0, K_NO, K_NO, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_NO, K_NO, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b1},
      // Near return with stack adjust
      '{3'd4, 1'b0, 1'b0, K_TM, K_MM, R_AX, R_SP, A_PS, F_NO, F_NO, S_PO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_SP, R_AX, A_AD, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_SP, R_AX, A_AD, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_TM, K_TM, R_AX, R_AX, A_AN, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_NO, K_TM, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b1},
      '0,
      // Frame teardown, shared by selects 4 to 7
      '{3'd4, 1'b0, 1'b0, K_RG, K_RG, R_SP, R_BP, A_PS, F_NO, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_MM, R_BP, R_SP, A_PS, F_NO, F_NO, S_PO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_RG, K_IM, R_SP, R_AX, A_AD, F_NO, F_NO, S_NO, 1'b0},
      '{3'd2, 1'b0, 1'b0, K_TM, K_NO, R_AX, R_AX, A_PS, F_CF, F_NO, S_NO, 1'b0},
      '{3'd4, 1'b0, 1'b0, K_NO, K_NO, R_AX, R_AX, A_PS, F_NO, F_NO, S_NO, 1'b1},
      '0,
      '0,
      '0
   };

   function automatic logic [4:0] prog_offset(prog_sel_t sel);
      case (sel)
         3'd0:    return 5'd0;
         3'd1:    return 5'd4;
         3'd2:    return 5'd10;
         3'd3:    return 5'd18;
         default: return 5'd24;
      endcase
   endfunction

   function automatic logic [4:0] prog_length(prog_sel_t sel);
      case (sel)
         3'd0:    return 5'd4;
         3'd1:    return 5'd6;
         3'd2:    return 5'd8;
         default: return 5'd5;
      endcase
   endfunction

endpackage

// File: hw/credit_fifo.sv
module credit_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     wr_valid,
   input  payload_t wr_data,
   input  logic     pop,
   output logic     rd_valid,
   output payload_t rd_data,
   output logic     credit
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign rd_valid = fill != '0;
   assign rd_data  = mem[rd_ptr];
   assign do_pop   = pop && rd_valid;

   always_ff @(posedge clk) begin
      if (wr_valid) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({wr_valid, do_pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // One credit back upstream per freed entry
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit <= 1'b0;
      end else begin
         credit <= do_pop;
      end
   end

   // Upstream may only write while it holds a credit, so never into a full buffer
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!arst_n)
      wr_valid |-> (fill < DEPTH)
   ) else $error("credit_fifo write while full");

endmodule

// File: hw/ucode_sequencer.sv
module ucode_sequencer #(
   parameter int IADDR_W = ucode_pkg::IADDR_W
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  head_valid,
   input  ucode_pkg::dec_instr_t head_instr,
   input  logic                  can_issue,
   output logic                  head_pop,
   output logic                  issue,
   output ucode_pkg::uop_t       issue_uop
);

   import ucode_pkg::*;

   logic [4:0]         micro_count;
   logic [4:0]         micro_length;
   logic [4:0]         micro_offset;
   logic [4:0]         micro_addr;
   logic               pass_thru;
   logic               last_step;
   ucode_word_t        rom_word;
   logic [IADDR_W-1:0] instr_pc;

   if (IADDR_W != ucode_pkg::IADDR_W) begin : g_addr_w_check
      $error("ucode_sequencer IADDR_W differs from the package address width");
   end

   // Select zero is a single pass-through op
   assign pass_thru = head_instr.prog == '0;

   assign micro_length = prog_length(head_instr.prog);
   assign micro_offset = prog_offset(head_instr.prog);
   assign micro_addr   = micro_offset + micro_count;
   assign rom_word     = UCODE_ROM[micro_addr];

   assign last_step = pass_thru || (micro_count == micro_length - 5'd1);

   assign issue    = head_valid && can_issue;
   assign head_pop = issue && last_step;

   // Micro count, back to zero after the last step
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         micro_count <= '0;
      end else if (issue) begin
         if (last_step) begin
            micro_count <= '0;
         end else begin
            micro_count <= micro_count + 5'd1;
         end
      end
   end

   assign instr_pc = head_instr.pc;

   // Merge instruction operands with the selected row
   always_comb begin
      issue_uop.pc                 = instr_pc;
      issue_uop.modrm              = head_instr.modrm;
      issue_uop.sib                = head_instr.sib;
      issue_uop.imm                = head_instr.imm;
      issue_uop.disp               = head_instr.disp;
      issue_uop.seg_override       = head_instr.seg_override;
      issue_uop.seg_override_valid = head_instr.seg_override_valid;
      issue_uop.micro_idx          = micro_count;
      if (pass_thru) begin
         issue_uop.word      = head_instr.base;
         // a one-op program always ends on its first op
         issue_uop.word.last = 1'b1;
      end else begin
         issue_uop.word = rom_word;
      end
   end

   // A program in progress keeps its head instruction until the last step
   a_count_in_program: assert property (
      @(posedge clk) disable iff (!arst_n)
      (micro_count != '0) |-> (head_valid && !pass_thru && micro_count < micro_length)
   ) else $error("micro count outside the program at the FIFO head");

   // Table last marker agrees with the program length function
   a_last_matches_length: assert property (
      @(posedge clk) disable iff (!arst_n)
      (issue && !pass_thru) |-> (rom_word.last == last_step)
   ) else $error("table last marker disagrees with prog_length");

endmodule

// File: hw/credit_sender.sv
module credit_sender #(
   parameter int OUT_CREDITS = 3
) (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            issue,
   input  ucode_pkg::uop_t issue_uop,
   input  logic            out_credit,
   output logic            can_issue,
   output logic            out_valid,
   output ucode_pkg::uop_t out_uop
);

   localparam int CNT_W = $clog2(OUT_CREDITS + 1);

   logic [CNT_W-1:0] credit_cnt;

   assign can_issue = credit_cnt != '0;

   // Issue and a returned credit in one cycle cancel
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_cnt <= CNT_W'(OUT_CREDITS);
      end else begin
         case ({issue, out_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         out_uop <= issue_uop;
      end
   end

   a_no_credit_overflow: assert property (
      @(posedge clk) disable iff (!arst_n)
      (out_credit && !issue) |-> (credit_cnt < OUT_CREDITS)
   ) else $error("execute stage returned more credits than it was given");

   a_no_credit_underflow: assert property (
      @(posedge clk) disable iff (!arst_n)
      (issue && !out_credit) |-> (credit_cnt != '0)
   ) else $error("micro-op issued with no output credit");

endmodule

// File: hw/ucode_top.sv
module ucode_top #(
   parameter int IADDR_W     = ucode_pkg::IADDR_W,
   parameter int IN_DEPTH    = 4,
   parameter int OUT_CREDITS = 3
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  in_valid,
   input  ucode_pkg::dec_instr_t in_instr,
   output logic                  in_credit,
   output logic                  out_valid,
   output ucode_pkg::uop_t       out_uop,
   input  logic                  out_credit
);

   import ucode_pkg::*;

   logic       head_valid;
   dec_instr_t head_instr;
   logic       head_pop;
   logic       can_issue;
   logic       issue;
   uop_t       issue_uop;

   // Decoder side
   credit_fifo #(
      .payload_t (dec_instr_t),
      .DEPTH     (IN_DEPTH)
   ) i_credit_fifo (
      .clk      (clk),
      .arst_n   (arst_n),
      .wr_valid (in_valid),
      .wr_data  (in_instr),
      .pop      (head_pop),
      .rd_valid (head_valid),
      .rd_data  (head_instr),
      .credit   (in_credit)
   );

   ucode_sequencer #(
      .IADDR_W (IADDR_W)
   ) i_ucode_sequencer (
      .clk        (clk),
      .arst_n     (arst_n),
      .head_valid (head_valid),
      .head_instr (head_instr),
      .can_issue  (can_issue),
      .head_pop   (head_pop),
      .issue      (issue),
      .issue_uop  (issue_uop)
   );

   // Execute side
   credit_sender #(
      .OUT_CREDITS (OUT_CREDITS)
   ) i_credit_sender (
      .clk        (clk),
      .arst_n     (arst_n),
      .issue      (issue),
      .issue_uop  (issue_uop),
      .out_credit (out_credit),
      .can_issue  (can_issue),
      .out_valid  (out_valid),
      .out_uop    (out_uop)
   );

endmodule

// File: tb/ucode_tb_model.svh
`ifndef UCODE_TB_MODEL_SVH
`define UCODE_TB_MODEL_SVH

// Program lengths by select, select 0 itself is pass-through
localparam int PROG_LEN [8] = '{4, 6, 8, 5, 5, 5, 5, 5};

// First table row by select, selects 4 to 7 share the program at row 24
localparam int PROG_START [8] = '{0, 4, 10, 18, 24, 24, 24, 24};

function automatic int uop_count(prog_sel_t sel);
   if (sel == 3'd0) begin
      return 1;
   end
   return PROG_LEN[sel];
endfunction

// Expected micro-ops of one instruction, in issue order
task automatic push_expected(input dec_instr_t ins);
   uop_t u;
   int   n;
   n = uop_count(ins.prog);
   for (int i = 0; i < n; i++) begin
      u.pc                 = ins.pc;
      u.modrm              = ins.modrm;
      u.sib                = ins.sib;
      u.imm                = ins.imm;
      u.disp               = ins.disp;
      u.seg_override       = ins.seg_override;
      u.seg_override_valid = ins.seg_override_valid;
      u.micro_idx          = 5'(i);
      if (ins.prog == 3'd0) begin
         u.word      = ins.base;
         u.word.last = 1'b1;
      end else begin
         u.word = UCODE_ROM[PROG_START[ins.prog] + i];
      end
      exp_q.push_back(u);
      final_q.push_back(i == n - 1);
   end
endtask

`endif

// File: tb/ucode_tb.sv
module ucode_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import ucode_pkg::*;

   localparam int          IN_DEPTH    = 4;
   localparam int          OUT_CREDITS = 3;
   localparam int          NUM_INSTR   = 60;
   localparam int          WAIT_LIMIT  = 200;
   localparam int          DRAIN_LIMIT = 3000;
   localparam int          HOLD_START  = 200;
   localparam int          HOLD_END    = 260;
   localparam logic [15:0] SEED        = 16'd92;

   logic        clk;
   logic        arst_n;
   logic        in_valid;
   dec_instr_t  in_instr;
   logic        in_credit;
   logic        out_valid;
   uop_t        out_uop;
   logic        out_credit;

   uop_t        exp_q[$];
   logic        final_q[$];
   logic [15:0] stim_lfsr;
   logic [15:0] ret_lfsr;
   int          sent_total;
   int          credit_total;
   int          outstanding;
   int          pending;
   int          ret_delay;
   int          cycle;
   int          check_errors;
   int          timeout_errors;
   logic        hold_credits;

   `include "ucode_tb_model.svh"

   ucode_top #(
      .IADDR_W     (IADDR_W),
      .IN_DEPTH    (IN_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) i_ucode_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_instr   (in_instr),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_uop    (out_uop),
      .out_credit (out_credit)
   );

   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
   endfunction

   task automatic draw_bits(inout logic [15:0] state, input int n, output logic [63:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         state = lfsr_next(state);
         val   = {val[62:0], state[0]};
      end
   endtask

   task automatic make_instr(output dec_instr_t ins);
      logic [63:0] r;
      ins = '0;
      draw_bits(stim_lfsr, 32, r);
      ins.pc = r[31:0];
      draw_bits(stim_lfsr, 3, r);
      ins.prog = r[2:0];
      draw_bits(stim_lfsr, 16, r);
      ins.modrm = r[15:8];
      ins.sib   = r[7:0];
      draw_bits(stim_lfsr, 48, r);
      ins.imm = r[47:0];
      draw_bits(stim_lfsr, 36, r);
      ins.disp               = r[31:0];
      ins.seg_override       = r[34:32];
      ins.seg_override_valid = r[35];
      draw_bits(stim_lfsr, $bits(ucode_word_t), r);
      ins.base = ucode_word_t'(r[$bits(ucode_word_t)-1:0]);
   endtask

   task automatic check_reset_outputs();
      a_reset_quiet: assert (!out_valid && !in_credit) else begin
         check_errors++;
         $display("FAIL %0t: out_valid or in_credit high around reset", $time);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // Execute stage stalls for a stretch
   assign hold_credits = cycle >= HOLD_START && cycle < HOLD_END;

   // Execute stage model, one credit back per micro-op after a random delay
   always @(posedge clk) begin
      logic [63:0] r;
      int          returned;
      returned = 0;
      if (!arst_n) begin
         out_credit <= 1'b0;
         pending    <= 0;
         ret_delay  <= 0;
      end else begin
         if (pending > 0 && !hold_credits && ret_delay == 0) begin
            draw_bits(ret_lfsr, 2, r);
            out_credit <= 1'b1;
            ret_delay  <= int'(r[1:0]);
            returned = 1;
         end else begin
            out_credit <= 1'b0;
            if (ret_delay > 0) begin
               ret_delay <= ret_delay - 1;
            end
         end
         pending <= pending + int'(out_valid) - returned;
      end
   end

   always @(posedge clk) begin
      uop_t exp_uop;
      logic exp_final;
      int   next_out;
      if (arst_n) begin
         next_out = outstanding + int'(out_valid) - int'(out_credit);
         a_out_credit_bound: assert (next_out <= OUT_CREDITS) else begin
            check_errors++;
            $display("FAIL %0t: %0d micro-ops outstanding, limit %0d",
                     $time, next_out, OUT_CREDITS);
         end
         outstanding <= next_out;
         if (in_credit) begin
            a_in_credit_bound: assert (credit_total < sent_total) else begin
               check_errors++;
               $display("FAIL %0t: in_credit pulse %0d with only %0d sent",
                        $time, credit_total + 1, sent_total);
            end
            credit_total <= credit_total + 1;
         end
         if (out_valid) begin
            if (exp_q.size() == 0) begin
               check_errors++;
               $display("Micro-op at %0t arrived when none was expected", $time);
            end else begin
               exp_uop   = exp_q.pop_front();
               exp_final = final_q.pop_front();
               a_uop_fields: assert (out_uop == exp_uop) else begin
                  check_errors++;
                  $display("FAIL %0t: pc %h idx %0d expected %h got %h", $time,
                           exp_uop.pc, exp_uop.micro_idx, exp_uop, out_uop);
               end
               a_last_flag: assert (out_uop.word.last == exp_final) else begin
                  check_errors++;
                  $display("FAIL %0t: last flag %b on micro index %0d",
                           $time, out_uop.word.last, out_uop.micro_idx);
               end
            end
         end
      end
   end

   initial begin
      dec_instr_t  ins;
      logic [63:0] r;
      int          wait_cnt;
      logic        aborted;
      arst_n         = 1'b0;
      in_valid       = 1'b0;
      in_instr       = '0;
      out_credit     = 1'b0;
      stim_lfsr      = SEED;
      ret_lfsr       = SEED;
      sent_total     = 0;
      credit_total   = 0;
      outstanding    = 0;
      cycle          = 0;
      check_errors   = 0;
      timeout_errors = 0;
      aborted        = 1'b0;
      repeat (10) begin
         @(posedge clk);
         check_reset_outputs();
      end
      arst_n <= 1'b1;
      @(posedge clk);
      check_reset_outputs();
      for (int n = 0; n < NUM_INSTR && !aborted; n++) begin
         make_instr(ins);
         draw_bits(stim_lfsr, 2, r);
         repeat (int'(r[1:0])) begin
            @(posedge clk);
         end
         // Decoder sends only while it holds an input credit
         wait_cnt = 0;
         while (IN_DEPTH - sent_total + credit_total == 0 && wait_cnt < WAIT_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
         end
         if (wait_cnt >= WAIT_LIMIT) begin
            timeout_errors++;
            aborted = 1'b1;
            $display("Timeout at %0t: no input credit came back from the DUT", $time);
         end else begin
            in_valid   <= 1'b1;
            in_instr   <= ins;
            sent_total <= sent_total + 1;
            push_expected(ins);
            @(posedge clk);
            in_valid <= 1'b0;
         end
      end
      wait_cnt = 0;
      while (!aborted && (exp_q.size() != 0 || credit_total != sent_total)
             && wait_cnt < DRAIN_LIMIT) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (wait_cnt >= DRAIN_LIMIT) begin
         timeout_errors++;
         $display("Timeout at %0t: DUT did not drain, %0d micro-ops still expected",
                  $time, exp_q.size());
      end
      // Quiet tail, any duplicate would show up here
      repeat (10) begin
         @(posedge clk);
      end
      a_all_delivered: assert (exp_q.size() == 0) else begin
         check_errors++;
         $display("FAIL %0t: %0d expected micro-ops never arrived", $time, exp_q.size());
      end
      a_credits_home: assert (IN_DEPTH - sent_total + credit_total == IN_DEPTH) else begin
         check_errors++;
         $display("FAIL %0t: decoder holds %0d input credits, expected %0d",
                  $time, IN_DEPTH - sent_total + credit_total, IN_DEPTH);
      end
      $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+tb
hw/ucode_pkg.sv
hw/credit_fifo.sv
hw/ucode_sequencer.sv
hw/credit_sender.sv
hw/ucode_top.sv
tb/ucode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ucode_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

FAIL_MSG := test failed
PASS_MSG := test passed
SOURCES  := $(FILELIST) $(wildcard hw/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
